// File: hdl/acc_pkg.sv
`default_nettype none

package acc_pkg;

    // event format
    localparam int NUM_SURFS         = 7;
    localparam int SAMPLES_PER_CHUNK = 384;
    localparam int CHUNKS_PER_EVENT  = 4;
    // one chunk holds every SURF's slice back to back
    localparam int CHUNK_WORDS       = NUM_SURFS * SAMPLES_PER_CHUNK;

    // per-SURF input FIFO depth in words
    localparam int FIFO_DEPTH        = 16;
    // array read register plus output register
    localparam int READ_LATENCY      = 2;

    typedef logic [63:0] word_t;
    typedef logic [11:0] buf_addr_t;
    typedef logic [8:0]  sample_idx_t;
    typedef logic [2:0]  surf_idx_t;
    // low bit picks the bank
    typedef logic [1:0]  chunk_idx_t;

    // each WRITE_n writes SURF n and latches the word of the SURF after it
    typedef enum logic [3:0] {
        IDLE,
        PREP_0,
        WRITE_0, WRITE_1, WRITE_2, WRITE_3, WRITE_4, WRITE_5, WRITE_6,
        SIGNAL_READOUT,
        PAUSE
    } wr_state_t;

endpackage

`default_nettype wire

// File: hdl/chunk_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module chunk_buffer (
    input  wire      memclk,
    chunk_ram_if.ram ram
);

    // bank 0 and bank 1, each one full chunk
    acc_pkg::word_t mem [2][acc_pkg::CHUNK_WORDS];

    // stage 0 is the array read register, the rest are output registers
    acc_pkg::word_t rd_pipe [acc_pkg::READ_LATENCY];

    always_ff @(posedge memclk) begin
        if (ram.wr_en) begin
            mem[ram.wr_bank][ram.wr_addr] <= ram.wr_data;
        end
    end

    // array read only when asked, so the stage holds between bursts
    always_ff @(posedge memclk) begin
        if (ram.rd_en) begin
            rd_pipe[0] <= mem[ram.rd_bank][ram.rd_addr];
        end
    end

    // output registers run freely, the reader tracks validity
    always_ff @(posedge memclk) begin
        for (int k = 1; k < acc_pkg::READ_LATENCY; k++) begin
            rd_pipe[k] <= rd_pipe[k-1];
        end
    end

    assign ram.rd_data = rd_pipe[acc_pkg::READ_LATENCY-1];

endmodule

`default_nettype wire

// File: hdl/chunk_ram_if.sv
`timescale 1ns/100ps
`default_nettype none

interface chunk_ram_if;

    // write port, owned by the write sequencer
    logic              wr_en;
    logic              wr_bank;
    acc_pkg::buf_addr_t wr_addr;
    acc_pkg::word_t    wr_data;

    // read port, issued by the readout sequencer
    logic              rd_en;
    logic              rd_bank;
    acc_pkg::buf_addr_t rd_addr;
    // comes back READ_LATENCY cycles after rd_en
    acc_pkg::word_t    rd_data;

    modport writer (output wr_en, wr_bank, wr_addr, wr_data);

    modport reader (output rd_en, rd_bank, rd_addr, input rd_data);

    modport ram (
        input  wr_en, wr_bank, wr_addr, wr_data,
        input  rd_en, rd_bank, rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

// File: hdl/chunk_reader.sv
`timescale 1ns/100ps
`default_nettype none

module chunk_reader (
    input  wire                 memclk,
    input  wire                 memresetn,
    input  wire                 chunk_done_i,
    input  acc_pkg::chunk_idx_t chunk_id_i,
    chunk_ram_if.reader         ram,
    output logic [1:0]          bank_clear_o,
    input  wire                 payload_has_space_i,
    output acc_pkg::word_t      payload_o,
    output logic [4:0]          payload_ident_o,
    output logic                payload_valid_o,
    output logic                payload_last_o
);

    // queue of finished chunks waiting for readout
    acc_pkg::chunk_idx_t queue [4];
    logic [1:0]          q_wr_ptr;
    logic [1:0]          q_rd_ptr;
    logic [2:0]          q_count;
    logic                q_pop;

    // burst state
    logic                 rd_active;
    acc_pkg::chunk_idx_t  rd_chunk;
    acc_pkg::buf_addr_t   rd_addr;
    acc_pkg::sample_idx_t rd_sample;
    acc_pkg::surf_idx_t   rd_surf;
    logic                 last_sample;

    // tags travelling next to the RAM read
    logic [acc_pkg::READ_LATENCY-1:0] vld_pipe;
    logic [acc_pkg::READ_LATENCY-1:0] last_pipe;
    acc_pkg::surf_idx_t               surf_pipe [acc_pkg::READ_LATENCY];
    acc_pkg::chunk_idx_t              chunk_pipe [acc_pkg::READ_LATENCY];
    logic                             chunk_end;

    // has-space only matters at the start of a chunk
    assign q_pop       = !rd_active && (q_count != 0) && payload_has_space_i;
    assign last_sample = (rd_sample == acc_pkg::SAMPLES_PER_CHUNK - 1);

    assign ram.rd_en   = rd_active;
    assign ram.rd_bank = rd_chunk[0];
    assign ram.rd_addr = rd_addr;

    always_ff @(posedge memclk) begin
        if (chunk_done_i) begin
            queue[q_wr_ptr] <= chunk_id_i;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            q_wr_ptr  <= '0;
            q_rd_ptr  <= '0;
            q_count   <= '0;
            rd_active <= 1'b0;
        end else begin
            if (chunk_done_i) q_wr_ptr <= q_wr_ptr + 1'b1;
            if (q_pop) q_rd_ptr <= q_rd_ptr + 1'b1;
            if (chunk_done_i && !q_pop) begin
                q_count <= q_count + 1'b1;
            end else if (q_pop && !chunk_done_i) begin
                q_count <= q_count - 1'b1;
            end
            // a started chunk runs to its last word without a gap
            if (q_pop) begin
                rd_active <= 1'b1;
            end else if (last_sample && rd_surf == acc_pkg::NUM_SURFS - 1) begin
                rd_active <= 1'b0;
            end
        end
    end

    // linear walk through the bank, counting samples within each SURF
    always_ff @(posedge memclk) begin
        if (!rd_active) begin
            rd_addr   <= '0;
            rd_sample <= '0;
            rd_surf   <= '0;
            if (q_pop) rd_chunk <= queue[q_rd_ptr];
        end else begin
            rd_addr   <= rd_addr + 1'b1;
            rd_sample <= last_sample ? '0 : rd_sample + 1'b1;
            if (last_sample) rd_surf <= rd_surf + 1'b1;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            vld_pipe  <= '0;
            last_pipe <= '0;
        end else begin
            vld_pipe[0]  <= rd_active;
            // sample counter rests at zero outside a burst
            last_pipe[0] <= last_sample;
            for (int k = 1; k < acc_pkg::READ_LATENCY; k++) begin
                vld_pipe[k]  <= vld_pipe[k-1];
                last_pipe[k] <= last_pipe[k-1];
            end
        end
    end

    always_ff @(posedge memclk) begin
        surf_pipe[0]  <= rd_surf;
        chunk_pipe[0] <= rd_chunk;
        for (int k = 1; k < acc_pkg::READ_LATENCY; k++) begin
            surf_pipe[k]  <= surf_pipe[k-1];
            chunk_pipe[k] <= chunk_pipe[k-1];
        end
    end

    assign payload_o       = ram.rd_data;
    assign payload_valid_o = vld_pipe[acc_pkg::READ_LATENCY-1];
    assign payload_last_o  = last_pipe[acc_pkg::READ_LATENCY-1];
    // identity is chunk * 8 + SURF
    assign payload_ident_o = {chunk_pipe[acc_pkg::READ_LATENCY-1],
                              surf_pipe[acc_pkg::READ_LATENCY-1]};

    // the last word of SURF 6 frees the bank
    assign chunk_end = payload_last_o &&
                       (surf_pipe[acc_pkg::READ_LATENCY-1] == acc_pkg::NUM_SURFS - 1);
    assign bank_clear_o[0] = chunk_end && !chunk_pipe[acc_pkg::READ_LATENCY-1][0];
    assign bank_clear_o[1] = chunk_end && chunk_pipe[acc_pkg::READ_LATENCY-1][0];

    // two banks bound the writer, so four entries never fill past capacity
    a_queue_no_overflow: assert property (@(posedge memclk) disable iff (!memresetn)
        chunk_done_i |-> (q_count != 3'd4 || q_pop));

    a_last_needs_valid: assert property (@(posedge memclk) disable iff (!memresetn)
        payload_last_o |-> payload_valid_o);

endmodule

`default_nettype wire

// File: hdl/chunk_writer.sv
`timescale 1ns/100ps
`default_nettype none

module chunk_writer (
    input  wire                                     memclk,
    input  wire                                     memresetn,
    input  acc_pkg::word_t [acc_pkg::NUM_SURFS-1:0] fifo_data_i,
    input  wire  [acc_pkg::NUM_SURFS-1:0]           fifo_valid_i,
    input  wire  [acc_pkg::NUM_SURFS-1:0]           fifo_almost_empty_i,
    output logic [acc_pkg::NUM_SURFS-1:0]           fifo_pop_o,
    chunk_ram_if.writer                             ram,
    output logic                                    chunk_done_o,
    output acc_pkg::chunk_idx_t                     chunk_id_o,
    input  wire  [1:0]                              bank_clear_i
);

    acc_pkg::wr_state_t   state;
    acc_pkg::sample_idx_t sample_cnt;
    acc_pkg::chunk_idx_t  chunk_cnt;
    logic [1:0]           bank_full;

    // word latched one state ahead of its write
    acc_pkg::word_t       data_q;

    logic                 in_write;
    acc_pkg::surf_idx_t   cur_surf;
    acc_pkg::surf_idx_t   next_surf;
    logic                 all_valid;
    logic                 all_next_valid;

    // WRITE_0..WRITE_6 are contiguous in the enum
    assign in_write = (state >= acc_pkg::WRITE_0) && (state <= acc_pkg::WRITE_6);
    assign cur_surf = acc_pkg::surf_idx_t'(state - acc_pkg::WRITE_0);
    // after SURF 6 (and in PREP_0) the next word to latch is SURF 0
    assign next_surf = (in_write && cur_surf != acc_pkg::NUM_SURFS - 1) ?
                       cur_surf + 1'b1 : '0;

    // PREP_0 needs a word from every SURF before the round starts
    assign all_valid = &fifo_valid_i;
    // SURF 6 is being popped right now, so it must hold a second word
    assign all_next_valid = (&fifo_valid_i[acc_pkg::NUM_SURFS-2:0]) &&
                            !fifo_almost_empty_i[acc_pkg::NUM_SURFS-1];

    // the FIFO output is still the same word during the pop cycle
    assign fifo_pop_o = in_write ? (acc_pkg::NUM_SURFS'(1) << cur_surf) : '0;

    assign ram.wr_en   = in_write;
    assign ram.wr_bank = chunk_cnt[0];
    // each SURF owns a contiguous slice of the bank
    assign ram.wr_addr = acc_pkg::buf_addr_t'(cur_surf * acc_pkg::SAMPLES_PER_CHUNK) +
                         acc_pkg::buf_addr_t'(sample_cnt);
    assign ram.wr_data = data_q;

    assign chunk_done_o = (state == acc_pkg::SIGNAL_READOUT);
    assign chunk_id_o   = chunk_cnt;

    always_ff @(posedge memclk) begin
        data_q <= fifo_data_i[next_surf];
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state      <= acc_pkg::IDLE;
            sample_cnt <= '0;
            chunk_cnt  <= '0;
        end else begin
            unique case (state)
                acc_pkg::IDLE: begin
                    sample_cnt <= '0;
                    // every event starts in bank 0
                    if (fifo_valid_i[0] && !bank_full[0]) state <= acc_pkg::PREP_0;
                end
                acc_pkg::PREP_0: begin
                    if (all_valid) state <= acc_pkg::WRITE_0;
                end
                acc_pkg::WRITE_6: begin
                    if (sample_cnt == acc_pkg::SAMPLES_PER_CHUNK - 1) begin
                        sample_cnt <= '0;
                        state      <= acc_pkg::SIGNAL_READOUT;
                    end else begin
                        sample_cnt <= sample_cnt + 1'b1;
                        // full rate if nobody ran dry, else regroup
                        state <= all_next_valid ? acc_pkg::WRITE_0 : acc_pkg::PREP_0;
                    end
                end
                acc_pkg::SIGNAL_READOUT: begin
                    // 2-bit count wraps back to chunk 0 for the next event
                    chunk_cnt <= chunk_cnt + 1'b1;
                    if (chunk_cnt == acc_pkg::chunk_idx_t'(acc_pkg::CHUNKS_PER_EVENT - 1)) begin
                        state <= acc_pkg::IDLE;
                    end else if (!bank_full[~chunk_cnt[0]]) begin
                        state <= acc_pkg::PREP_0;
                    end else begin
                        state <= acc_pkg::PAUSE;
                    end
                end
                acc_pkg::PAUSE: begin
                    // chunk count already points at the new bank
                    if (!bank_full[chunk_cnt[0]]) state <= acc_pkg::PREP_0;
                end
                default: begin
                    // WRITE_0..WRITE_5 just walk to the next SURF
                    state <= acc_pkg::wr_state_t'(state + 1'b1);
                end
            endcase
        end
    end

    // bank flags, set by the first write and cleared once read out
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            bank_full <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (bank_clear_i[b]) begin
                    bank_full[b] <= 1'b0;
                end else if (in_write && chunk_cnt[0] == b[0]) begin
                    bank_full[b] <= 1'b1;
                end
            end
        end
    end

    // a new chunk only lands in a bank the reader has released
    a_bank_free: assert property (@(posedge memclk) disable iff (!memresetn)
        (state == acc_pkg::WRITE_0 && sample_cnt == '0) |-> !bank_full[chunk_cnt[0]]);

endmodule

`default_nettype wire

// File: hdl/event_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module event_accumulator (
    input  wire                                     memclk,
    input  wire                                     memresetn,
    input  acc_pkg::word_t [acc_pkg::NUM_SURFS-1:0] s_data_i,
    input  wire  [acc_pkg::NUM_SURFS-1:0]           s_valid_i,
    output logic [acc_pkg::NUM_SURFS-1:0]           s_ready_o,
    output acc_pkg::word_t                          payload_o,
    output logic [4:0]                              payload_ident_o,
    output logic                                    payload_valid_o,
    output logic                                    payload_last_o,
    input  wire                                     payload_has_space_i
);

    // FIFO outputs toward the write sequencer
    acc_pkg::word_t [acc_pkg::NUM_SURFS-1:0] fifo_data;
    logic [acc_pkg::NUM_SURFS-1:0]           fifo_valid;
    logic [acc_pkg::NUM_SURFS-1:0]           fifo_almost_empty;
    logic [acc_pkg::NUM_SURFS-1:0]           fifo_pop;

    // writer to reader handoff and bank release
    logic                chunk_done;
    acc_pkg::chunk_idx_t chunk_id;
    logic [1:0]          bank_clear;

    chunk_ram_if ram_bus ();

    // one FIFO per SURF stream
    for (genvar i = 0; i < acc_pkg::NUM_SURFS; i++) begin : g_fifo
        surf_word_fifo surf_word_fifo_inst (
            .memclk         (memclk),
            .memresetn      (memresetn),
            .wr_data_i      (s_data_i[i]),
            .wr_en_i        (s_valid_i[i]),
            .ready_o        (s_ready_o[i]),
            .data_o         (fifo_data[i]),
            .valid_o        (fifo_valid[i]),
            .almost_empty_o (fifo_almost_empty[i]),
            .pop_i          (fifo_pop[i])
        );
    end

    chunk_writer chunk_writer_inst (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .fifo_data_i         (fifo_data),
        .fifo_valid_i        (fifo_valid),
        .fifo_almost_empty_i (fifo_almost_empty),
        .fifo_pop_o          (fifo_pop),
        .ram                 (ram_bus),
        .chunk_done_o        (chunk_done),
        .chunk_id_o          (chunk_id),
        .bank_clear_i        (bank_clear)
    );

    chunk_buffer chunk_buffer_inst (
        .memclk (memclk),
        .ram    (ram_bus)
    );

    chunk_reader chunk_reader_inst (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .chunk_done_i        (chunk_done),
        .chunk_id_i          (chunk_id),
        .ram                 (ram_bus),
        .bank_clear_o        (bank_clear),
        .payload_has_space_i (payload_has_space_i),
        .payload_o           (payload_o),
        .payload_ident_o     (payload_ident_o),
        .payload_valid_o     (payload_valid_o),
        .payload_last_o      (payload_last_o)
    );

endmodule

`default_nettype wire

// File: hdl/surf_word_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module surf_word_fifo (
    input  wire            memclk,
    input  wire            memresetn,
    input  acc_pkg::word_t wr_data_i,
    input  wire            wr_en_i,
    output logic           ready_o,
    output acc_pkg::word_t data_o,
    output logic           valid_o,
    output logic           almost_empty_o,
    input  wire            pop_i
);

    // circular storage
    acc_pkg::word_t mem [acc_pkg::FIFO_DEPTH];

    logic [$clog2(acc_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(acc_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    // one extra bit so a full FIFO is distinguishable from empty
    logic [$clog2(acc_pkg::FIFO_DEPTH):0]   count;

    logic push;

    // upstream only gets accepted while there is room
    assign push = wr_en_i && ready_o;

    assign ready_o        = (count != acc_pkg::FIFO_DEPTH);
    assign valid_o        = (count != 0);
    // writer uses this to know a pop still leaves a word behind
    assign almost_empty_o = (count <= 1);
    // first word falls through, pop just advances
    assign data_o         = mem[rd_ptr];

    always_ff @(posedge memclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the level alone
            if (push && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // the writer pops by state alone, so its sequencing must guarantee data
    a_no_pop_empty: assert property (@(posedge memclk) disable iff (!memresetn)
        pop_i |-> (count != 0));

endmodule

`default_nettype wire

// File: verification/tb_event_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module tb_event_accumulator;

    localparam int NUM_EVENTS     = 3;
    localparam int WORDS_PER_SURF = NUM_EVENTS * acc_pkg::CHUNKS_PER_EVENT *
                                    acc_pkg::SAMPLES_PER_CHUNK;
    localparam int TOTAL_WORDS    = NUM_EVENTS * acc_pkg::CHUNKS_PER_EVENT *
                                    acc_pkg::CHUNK_WORDS;
    // four cycles of slack per output word
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 4;
    // every FIFO full this long means the writer is stalled, not just busy
    localparam int STALL_CYCLES   = 256;

    logic                                    memclk;
    logic                                    memresetn;
    acc_pkg::word_t [acc_pkg::NUM_SURFS-1:0] s_data;
    logic [acc_pkg::NUM_SURFS-1:0]           s_valid;
    logic [acc_pkg::NUM_SURFS-1:0]           s_ready;
    acc_pkg::word_t                          payload;
    logic [4:0]                              payload_ident;
    logic                                    payload_valid;
    logic                                    payload_last;
    logic                                    has_space;

    // per-SURF stimulus position
    int drv_e [acc_pkg::NUM_SURFS];
    int drv_c [acc_pkg::NUM_SURFS];
    int drv_n [acc_pkg::NUM_SURFS];
    int space_cnt;
    int ready_low_run;
    logic saw_ready_low;
    logic [31:0] lfsr;

    // expected output position
    int exp_e, exp_c, exp_s, exp_n;
    int words_seen;
    logic all_out;
    acc_pkg::word_t exp_data;
    int cycle_cnt;

    int err_data, err_ident, err_last, err_gap, err_other;

    event_accumulator event_accumulator_inst (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .s_data_i            (s_data),
        .s_valid_i           (s_valid),
        .s_ready_o           (s_ready),
        .payload_o           (payload),
        .payload_ident_o     (payload_ident),
        .payload_valid_o     (payload_valid),
        .payload_last_o      (payload_last),
        .payload_has_space_i (has_space)
    );

    // word for event e, chunk c, SURF s, sample n
    function automatic acc_pkg::word_t expected_word(input int e, input int c,
                                                     input int s, input int n);
        return {8'hea, 8'(e), 8'(c), 8'(s), 16'(n), 16'(n) ^ 16'h5a5a};
    endfunction

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one LFSR step per bit taken
    function int rand_bits(input int width);
        int v;
        v = 0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic print_counts();
        $display("errors: data %0d ident %0d last %0d gap %0d other %0d",
                 err_data, err_ident, err_last, err_gap, err_other);
    endtask

    initial begin
        memclk = 1'b0;
        forever #5 memclk = ~memclk;
    end

    // stimulus on the falling edge
    always @(negedge memclk) begin
        if (memresetn) begin
            for (int s = 0; s < acc_pkg::NUM_SURFS; s++) begin
                s_valid[s] = 1'b0;
                // event 0 runs gap free, later events get 25% gaps
                if (drv_e[s] < NUM_EVENTS && (drv_e[s] == 0 || rand_bits(2) != 3)) begin
                    s_valid[s] = 1'b1;
                    s_data[s]  = expected_word(drv_e[s], drv_c[s], s, drv_n[s]);
                end
                // ready only moves on the rising edge, so this is what the DUT sees
                if (s_valid[s] && s_ready[s]) begin
                    drv_n[s]++;
                    if (drv_n[s] == acc_pkg::SAMPLES_PER_CHUNK) begin
                        drv_n[s] = 0;
                        drv_c[s]++;
                    end
                    if (drv_c[s] == acc_pkg::CHUNKS_PER_EVENT) begin
                        drv_c[s] = 0;
                        drv_e[s]++;
                    end
                end
            end
            // long has-space outages while event 2 is fed in
            if (drv_e[0] == 2) begin
                if (space_cnt == 0) begin
                    has_space = !has_space;
                    space_cnt = has_space ? 3000 + rand_bits(10) : 6000 + rand_bits(10);
                end else begin
                    space_cnt--;
                end
            end else begin
                has_space = 1'b1;
            end
            // a held-off reader stalls the writer until every FIFO is full
            if (!has_space && s_ready == '0) begin
                ready_low_run++;
                if (ready_low_run == STALL_CYCLES) saw_ready_low = 1'b1;
            end else begin
                ready_low_run = 0;
            end
        end
    end

    // compare on the falling edge where the registered outputs are settled
    always @(negedge memclk) begin
        if (memresetn) begin
            if (payload_valid) begin
                if (all_out) begin
                    err_other++;
                    $display("unexpected extra output word at %0t after all events", $time);
                end else begin
                    exp_data = expected_word(exp_e, exp_c, exp_s, exp_n);
                    if (payload !== exp_data) begin
                        err_data++;
                        $display("CHECK FAILED %0t: data %h expected %h (e%0d c%0d s%0d n%0d)",
                                 $time, payload, exp_data, exp_e, exp_c, exp_s, exp_n);
                    end
                    if (payload_ident !== 5'(exp_c * 8 + exp_s)) begin
                        err_ident++;
                        $display("CHECK FAILED %0t: ident %0d expected %0d",
                                 $time, payload_ident, exp_c * 8 + exp_s);
                    end
                    if (payload_last !== (exp_n == acc_pkg::SAMPLES_PER_CHUNK - 1)) begin
                        err_last++;
                        $display("CHECK FAILED %0t: last %b at sample %0d",
                                 $time, payload_last, exp_n);
                    end
                    // walk sample, then SURF, then chunk, then event
                    exp_n++;
                    if (exp_n == acc_pkg::SAMPLES_PER_CHUNK) begin
                        exp_n = 0;
                        exp_s++;
                    end
                    if (exp_s == acc_pkg::NUM_SURFS) begin
                        exp_s = 0;
                        exp_c++;
                    end
                    if (exp_c == acc_pkg::CHUNKS_PER_EVENT) begin
                        exp_c = 0;
                        exp_e++;
                    end
                    words_seen++;
                    if (words_seen == TOTAL_WORDS) all_out = 1'b1;
                end
            end else if (exp_s != 0 || exp_n != 0) begin
                // a started chunk must stream without a hole
                err_gap++;
                $display("CHECK FAILED %0t: valid dropped inside chunk %0d at surf %0d sample %0d",
                         $time, exp_c, exp_s, exp_n);
            end
        end
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (all_out !== 1'b1 && cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge memclk);
            cycle_cnt++;
        end
        if (all_out !== 1'b1) begin
            $display("timeout: output stalled after %0d of %0d words", words_seen, TOTAL_WORDS);
            print_counts();
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        memresetn     = 1'b0;
        s_valid       = '0;
        s_data        = '0;
        has_space     = 1'b1;
        space_cnt     = 0;
        ready_low_run = 0;
        saw_ready_low = 1'b0;
        lfsr          = 32'hda2f_34a5;
        for (int s = 0; s < acc_pkg::NUM_SURFS; s++) begin
            drv_e[s] = 0;
            drv_c[s] = 0;
            drv_n[s] = 0;
        end
        exp_e      = 0;
        exp_c      = 0;
        exp_s      = 0;
        exp_n      = 0;
        words_seen = 0;
        all_out    = 1'b0;
        err_data   = 0;
        err_ident  = 0;
        err_last   = 0;
        err_gap    = 0;
        err_other  = 0;

        repeat (10) @(posedge memclk);
        @(negedge memclk);
        memresetn <= 1'b1;

        wait (all_out);
        // give a stray extra word time to show up
        repeat (50) @(posedge memclk);

        if (!saw_ready_low) begin
            err_other++;
            $display("s_ready_o never stayed low through a has-space outage");
        end
        if (s_ready != '1) begin
            err_other++;
            $display("s_ready_o did not recover after the run, value %b", s_ready);
        end

        print_counts();
        if (err_data + err_ident + err_last + err_gap + err_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/acc_pkg.sv
hdl/chunk_ram_if.sv
hdl/surf_word_fifo.sv
hdl/chunk_writer.sv
hdl/chunk_buffer.sv
hdl/chunk_reader.sv
hdl/event_accumulator.sv
verification/tb_event_accumulator.sv
